// ==== msx_cart_pkg.sv ====
`default_nettype none

package msx_cart_pkg;

    typedef enum logic [2:0] {
        MAPPER_NONE,
        MAPPER_ASCII8,
        MAPPER_KOEI,
        MAPPER_WIZARDY,
        MAPPER_ASCII16
    } mapper_typ_t;

    typedef logic [15:0] cpu_addr_t;
    typedef logic [7:0]  cpu_data_t;
    typedef logic [7:0]  bank_t;
    typedef logic [26:0] mem_addr_t;
    typedef logic [24:0] rom_size_t;   // bytes
    typedef logic [15:0] sram_size_t;  // 256-byte units

    typedef struct packed {
        logic      mreq;
        logic      rd;
        logic      wr;
        cpu_addr_t addr;
        cpu_data_t data;
    } cpu_bus_t;

    typedef struct packed {
        mapper_typ_t mapper;
        rom_size_t   rom_size;
        sram_size_t  sram_size;
    } cart_cfg_t;

    typedef struct packed {
        mem_addr_t addr;
        logic      rnw;
        logic      ram_cs;
        logic      sram_cs;
    } mem_map_t;

    typedef struct packed {
        logic     valid;
        mem_map_t map;
    } mem_req_t;

    localparam mem_addr_t ADDR_IDLE         = '1;
    localparam bank_t     SRAM_BIT_WIZARDY  = 8'h80;
    localparam bank_t     SRAM_PAGES_ASCII8 = 8'h30; // pages 4,5
    localparam bank_t     SRAM_PAGES_KOEI   = 8'h34; // pages 2,4,5

endpackage

`default_nettype wire

// ==== cart_ascii8.sv ====
`default_nettype none

module cart_ascii8 (
    input  wire                          clk,
    input  wire                          reset,
    input  wire msx_cart_pkg::cpu_bus_t  cpu,
    input  wire msx_cart_pkg::cart_cfg_t cfg,
    input  wire                          mapper_id,
    output msx_cart_pkg::mem_map_t       map
);
    import msx_cart_pkg::*;

    logic       family_en;
    logic       mode_wizardy;
    logic       mode_koei;
    logic       cs;
    logic       reg_wr;
    logic       sram_exists;
    logic       sram_req;
    bank_t      sram_mask;
    bank_t      sram_bit;
    bank_t      sram_pages;
    logic [1:0] region;
    logic [1:0] slot;
    logic [7:0] page_bit;
    logic       sram_sel;
    mem_addr_t  rom_addr;
    mem_addr_t  sram_addr;

    bank_t      bank_r      [2][4];
    bank_t      sram_bank_r [2][4];
    logic [7:0] sram_en_r   [2];       // one bit per 8 KB page

    assign mode_wizardy = (cfg.mapper == MAPPER_WIZARDY);
    assign mode_koei    = (cfg.mapper == MAPPER_KOEI);
    assign family_en    = (cfg.mapper == MAPPER_ASCII8) | mode_koei | mode_wizardy;
    assign cs           = cpu.mreq & family_en & (^cpu.addr[15:14]); // 0x4000-0xbfff
    assign reg_wr       = cs & cpu.wr & (cpu.addr[15:13] == 3'b011);

    assign sram_exists = (cfg.sram_size != '0);
    assign sram_mask   = (cfg.sram_size[10:3] != 8'd0) ? cfg.sram_size[10:3] - 8'd1 : 8'd0;
    assign sram_bit    = mode_wizardy ? SRAM_BIT_WIZARDY : cfg.rom_size[20:13];
    assign sram_pages  = mode_koei ? SRAM_PAGES_KOEI : SRAM_PAGES_ASCII8;
    assign sram_req    = ((cpu.data & sram_bit) != 8'd0) & sram_exists;

    assign region   = cpu.addr[12:11];
    assign page_bit = 8'b0000_0100 << region;   // region 0 is page 2
    assign slot     = {cpu.addr[15], cpu.addr[13]};

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2; i++) begin
                sram_en_r[i] <= '0;
                for (int j = 0; j < 4; j++) begin
                    bank_r[i][j]      <= '0;
                    sram_bank_r[i][j] <= '0;
                end
            end
        end else if (reg_wr) begin
            if (sram_req) begin
                sram_en_r[mapper_id]           <= sram_en_r[mapper_id] | (page_bit & sram_pages);
                sram_bank_r[mapper_id][region] <= cpu.data & sram_mask;
            end else begin
                sram_en_r[mapper_id]      <= sram_en_r[mapper_id] & ~page_bit;
                bank_r[mapper_id][region] <= cpu.data;
            end
        end
    end

    assign sram_sel  = sram_en_r[mapper_id][cpu.addr[15:13]];
    assign rom_addr  = {6'd0, bank_r[mapper_id][slot], cpu.addr[12:0]};
    assign sram_addr = {6'd0, sram_bank_r[mapper_id][slot], cpu.addr[12:0]};

    always_comb begin
        map.addr    = cs ? (sram_sel ? sram_addr : rom_addr) : ADDR_IDLE;
        map.sram_cs = cs & sram_sel;
        map.ram_cs  = cs & ~sram_sel & cpu.rd & (rom_addr < {2'b00, cfg.rom_size});
        map.rnw     = ~(cs & sram_sel & cpu.wr); // only sram takes writes
    end

endmodule

`default_nettype wire

// ==== cart_ascii16.sv ====
`default_nettype none

module cart_ascii16 (
    input  wire                          clk,
    input  wire                          reset,
    input  wire msx_cart_pkg::cpu_bus_t  cpu,
    input  wire msx_cart_pkg::cart_cfg_t cfg,
    input  wire                          mapper_id,
    output msx_cart_pkg::mem_map_t       map
);
    import msx_cart_pkg::*;

    logic      cs;
    logic      wr_lo;
    logic      wr_hi;
    mem_addr_t rom_addr;

    bank_t     bank_r [2][2];   // [mapper_id][16 KB page]

    assign cs    = cpu.mreq & (cfg.mapper == MAPPER_ASCII16) & (^cpu.addr[15:14]);
    assign wr_lo = cs & cpu.wr & (cpu.addr[15:11] == 5'b01100); // 0x6000-0x67ff
    assign wr_hi = cs & cpu.wr & (cpu.addr[15:11] == 5'b01110); // 0x7000-0x77ff

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2; i++) begin
                bank_r[i][0] <= '0;
                bank_r[i][1] <= '0;
            end
        end else begin
            if (wr_lo) begin
                bank_r[mapper_id][0] <= cpu.data;
            end
            if (wr_hi) begin
                bank_r[mapper_id][1] <= cpu.data;
            end
        end
    end

    // addr[15] splits 0x4000-0x7fff from 0x8000-0xbfff
    assign rom_addr = {5'd0, bank_r[mapper_id][cpu.addr[15]], cpu.addr[13:0]};

    always_comb begin
        map.addr    = cs ? rom_addr : ADDR_IDLE;
        map.ram_cs  = cs & cpu.rd & (rom_addr < {2'b00, cfg.rom_size});
        map.sram_cs = 1'b0;
        map.rnw     = 1'b1;
    end

endmodule

`default_nettype wire

// ==== cart_mapper_sel.sv ====
`default_nettype none

module cart_mapper_sel (
    input  wire msx_cart_pkg::mapper_typ_t mapper,
    input  wire msx_cart_pkg::mem_map_t    ascii8_map,
    input  wire msx_cart_pkg::mem_map_t    ascii16_map,
    output msx_cart_pkg::mem_map_t         map
);
    import msx_cart_pkg::*;

    always_comb begin
        case (mapper)
            MAPPER_ASCII8,
            MAPPER_KOEI,
            MAPPER_WIZARDY: begin
                map = ascii8_map;
            end
            MAPPER_ASCII16: begin
                map = ascii16_map;
            end
            default: begin    // no cartridge mapper
                map.addr    = ADDR_IDLE;
                map.rnw     = 1'b1;
                map.ram_cs  = 1'b0;
                map.sram_cs = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== cart_mem_req.sv ====
`default_nettype none

module cart_mem_req (
    input  wire                         clk,
    input  wire                         reset,
    input  wire msx_cart_pkg::cpu_bus_t cpu,
    input  wire msx_cart_pkg::mem_map_t map,
    output msx_cart_pkg::mem_req_t      req
);
    import msx_cart_pkg::*;

    logic     mreq_q;
    logic     cycle_start;
    logic     hit;
    logic     valid_r;
    mem_map_t map_r;

    assign cycle_start = cpu.mreq & ~mreq_q;   // rising mreq
    assign hit         = map.ram_cs | map.sram_cs;

    always_ff @(posedge clk) begin
        if (reset) begin
            mreq_q  <= 1'b0;
            valid_r <= 1'b0;
        end else begin
            mreq_q  <= cpu.mreq;
            valid_r <= cycle_start & hit;
        end
    end

    // held until the next strobe
    always_ff @(posedge clk) begin
        if (cycle_start & hit) begin
            map_r <= map;
        end
    end

    assign req.valid = valid_r;
    assign req.map   = map_r;

endmodule

`default_nettype wire

// ==== msx_cart.sv ====
`default_nettype none

module msx_cart (
    input  wire                          clk,
    input  wire                          reset,
    input  wire msx_cart_pkg::cpu_bus_t  cpu,
    input  wire msx_cart_pkg::cart_cfg_t cfg,
    input  wire                          mapper_id,
    output msx_cart_pkg::mem_req_t       req
);
    import msx_cart_pkg::*;

    mem_map_t ascii8_map;
    mem_map_t ascii16_map;
    mem_map_t sel_map;

    cart_ascii8 i_ascii8 (
        .clk       (clk),
        .reset     (reset),
        .cpu       (cpu),
        .cfg       (cfg),
        .mapper_id (mapper_id),
        .map       (ascii8_map)
    );

    cart_ascii16 i_ascii16 (
        .clk       (clk),
        .reset     (reset),
        .cpu       (cpu),
        .cfg       (cfg),
        .mapper_id (mapper_id),
        .map       (ascii16_map)
    );

    cart_mapper_sel i_mapper_sel (
        .mapper      (cfg.mapper),
        .ascii8_map  (ascii8_map),
        .ascii16_map (ascii16_map),
        .map         (sel_map)
    );

    cart_mem_req i_mem_req (
        .clk   (clk),
        .reset (reset),
        .cpu   (cpu),
        .map   (sel_map),
        .req   (req)
    );

endmodule

`default_nettype wire

// ==== tb_clock.sv ====
`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // period 20
    end

    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== msx_cart_chk.sv ====
`default_nettype none

module msx_cart_chk (
    input wire                         clk,
    input wire                         reset,
    input wire msx_cart_pkg::mem_req_t req
);

    int fail_double  = 0;
    int fail_both_cs = 0;
    int fail_rnw     = 0;
    int fail_reset   = 0;
    int fail_count;

    assign fail_count = fail_double + fail_both_cs + fail_rnw + fail_reset;

    strobe_single: assert property (@(posedge clk) disable iff (reset)
            req.valid |=> !req.valid)
        else begin
            fail_double++;
            $error("request strobe high for two cycles");
        end

    cs_exclusive: assert property (@(posedge clk) disable iff (reset)
            req.valid |-> !(req.map.ram_cs && req.map.sram_cs))
        else begin
            fail_both_cs++;
            $error("ram_cs and sram_cs both set");
        end

    write_is_sram: assert property (@(posedge clk) disable iff (reset)
            (req.valid && !req.map.rnw) |-> req.map.sram_cs)
        else begin
            fail_rnw++;
            $error("write strobe without sram_cs");
        end

    idle_after_reset: assert property (@(posedge clk) reset |=> !req.valid)
        else begin
            fail_reset++;
            $error("strobe in the cycle after reset");
        end

endmodule

bind msx_cart msx_cart_chk i_chk (
    .clk   (clk),
    .reset (reset),
    .req   (req)
);

`default_nettype wire

// ==== msx_cart_tb.sv ====
`default_nettype none

module msx_cart_tb;
    import msx_cart_pkg::*;

    localparam rom_size_t  ROM_SIZE   = 25'h008_0000;  // 512 KB so the sram bit is 0x40
    localparam sram_size_t SRAM_SIZE  = 16'd32;        // 8 KB
    localparam int         MAX_CYCLES = 3000;          // tests run a few hundred cycles

    logic      clk;
    logic      reset;
    cpu_bus_t  cpu;
    cart_cfg_t cfg;
    logic      mapper_id;
    mem_req_t  req;

    int seed           = 32'hd346_387e;
    int cycle_count    = 0;
    int mismatch_count = 0;
    int missing_count  = 0;

    // reference model state
    bank_t      ref_bank8   [2][4];
    bank_t      ref_sbank8  [2][4];
    logic [7:0] ref_sram_en [2];
    bank_t      ref_bank16  [2][2];

    tb_clock i_tb_clock (
        .clk   (clk),
        .reset (reset)
    );

    msx_cart i_msx_cart (
        .clk       (clk),
        .reset     (reset),
        .cpu       (cpu),
        .cfg       (cfg),
        .mapper_id (mapper_id),
        .req       (req)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    function automatic bank_t rand_bank(input bank_t mask);
        return bank_t'($random(seed)) & mask;
    endfunction

    function automatic cpu_addr_t rand_addr(input cpu_addr_t base, input cpu_addr_t span);
        return base | (cpu_addr_t'($random(seed)) & span);
    endfunction

    function automatic mem_map_t expect_map(input cpu_addr_t addr, input logic is_wr,
                                            input logic id);
        mem_map_t   m;
        logic [2:0] page;
        logic [1:0] idx;
        page      = addr[15:13];
        idx       = page[1:0] - 2'd2;   // pages 2..5 hold the four banks
        m.addr    = ADDR_IDLE;
        m.rnw     = 1'b1;
        m.ram_cs  = 1'b0;
        m.sram_cs = 1'b0;
        if (addr < 16'h4000 || addr >= 16'hc000) begin
            return m;
        end
        if (cfg.mapper inside {MAPPER_ASCII8, MAPPER_KOEI, MAPPER_WIZARDY}) begin
            if (ref_sram_en[id][page]) begin
                m.addr    = {6'd0, ref_sbank8[id][idx], addr[12:0]};
                m.sram_cs = 1'b1;
                m.rnw     = ~is_wr;
            end else begin
                m.addr   = {6'd0, ref_bank8[id][idx], addr[12:0]};
                m.ram_cs = ~is_wr & (m.addr < {2'b00, cfg.rom_size});
            end
        end else if (cfg.mapper == MAPPER_ASCII16) begin
            m.addr   = {5'd0, ref_bank16[id][addr[15]], addr[13:0]};
            m.ram_cs = ~is_wr & (m.addr < {2'b00, cfg.rom_size});
        end
        return m;
    endfunction

    function automatic void update_model(input cpu_addr_t addr, input cpu_data_t data,
                                         input logic id);
        logic [1:0] region;
        logic [2:0] page;
        bank_t      sram_bit;
        bank_t      sram_mask;
        region    = addr[12:11];
        page      = {1'b0, region} + 3'd2;
        sram_bit  = (cfg.mapper == MAPPER_WIZARDY) ? 8'h80 : bank_t'(cfg.rom_size >> 13);
        sram_mask = bank_t'(cfg.sram_size >> 3) - 8'd1;   // 2 KB units less one
        if (cfg.mapper == MAPPER_ASCII16) begin
            if (addr >= 16'h6000 && addr < 16'h6800) begin
                ref_bank16[id][0] = data;
            end else if (addr >= 16'h7000 && addr < 16'h7800) begin
                ref_bank16[id][1] = data;
            end
        end else if (cfg.mapper != MAPPER_NONE && addr >= 16'h6000 && addr < 16'h8000) begin
            if ((data & sram_bit) != 8'd0 && cfg.sram_size != '0) begin
                if (page == 3'd4 || page == 3'd5 ||
                        (cfg.mapper == MAPPER_KOEI && page == 3'd2)) begin
                    ref_sram_en[id][page] = 1'b1;
                end
                ref_sbank8[id][region] = data & sram_mask;
            end else begin
                ref_sram_en[id][page] = 1'b0;
                ref_bank8[id][region] = data;
            end
        end
    endfunction

    task automatic check_valid(input logic expected, input logic actual);
        if (expected && !actual) begin
            missing_count++;
            $display("at %0t: no request strobe one cycle after the memory cycle started",
                     $time);
        end else if (!expected && actual) begin
            mismatch_count++;
            $display("MISMATCH at %0t: req.valid expected 0, got 1", $time);
        end
    endtask

    task automatic check_map(input mem_map_t expected, input mem_map_t actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("MISMATCH at %0t: req.map expected %07h rnw/ram/sram %b%b%b, got %07h %b%b%b",
                     $time, expected.addr, expected.rnw, expected.ram_cs, expected.sram_cs,
                     actual.addr, actual.rnw, actual.ram_cs, actual.sram_cs);
        end
    endtask

    // mreq held three cycles then low for one
    task automatic cpu_cycle(input cpu_addr_t addr, input cpu_data_t data, input logic is_wr,
                             input logic id);
        mem_map_t exp_map;
        logic     exp_hit;
        exp_map   = expect_map(addr, is_wr, id);
        exp_hit   = exp_map.ram_cs | exp_map.sram_cs;
        cpu.mreq  = 1'b1;
        cpu.rd    = ~is_wr;
        cpu.wr    = is_wr;
        cpu.addr  = addr;
        cpu.data  = data;
        mapper_id = id;
        @(negedge clk);
        check_valid(exp_hit, req.valid);
        if (exp_hit && req.valid) begin
            check_map(exp_map, req.map);
        end
        if (is_wr) begin
            update_model(addr, data, id);
        end
        @(negedge clk);
        check_valid(1'b0, req.valid);
        @(negedge clk);
        cpu.mreq = 1'b0;
        cpu.rd   = 1'b0;
        cpu.wr   = 1'b0;
        @(negedge clk);
    endtask

    task automatic test_reset_state();
        mem_map_t exp_map;
        exp_map.addr    = '0;
        exp_map.rnw     = 1'b1;
        exp_map.ram_cs  = 1'b1;
        exp_map.sram_cs = 1'b0;
        cpu_cycle(16'h4000, 8'h00, 1'b0, 1'b0);
        check_map(exp_map, req.map);   // held until the next strobe
        cpu_cycle(16'h4000, 8'h00, 1'b0, 1'b1);
    endtask

    task automatic test_ascii8_banks();
        cfg.mapper = MAPPER_ASCII8;
        for (int r = 0; r < 4; r++) begin
            cpu_cycle(cpu_addr_t'(32'h6000 + 32'h0800 * r), rand_bank(8'h3f), 1'b1, 1'b0);
        end
        for (int p = 0; p < 4; p++) begin
            cpu_cycle(rand_addr(cpu_addr_t'(32'h4000 + 32'h2000 * p), 16'h1fff), 8'h00,
                      1'b0, 1'b0);
            cpu_cycle(cpu_addr_t'(32'h5fff + 32'h2000 * p), 8'h00, 1'b0, 1'b0);
        end
        cpu_cycle(16'h7000, 8'h90, 1'b1, 1'b0);   // past the rom image
        cpu_cycle(16'h8123, 8'h00, 1'b0, 1'b0);
        cpu_cycle(16'h4800, 8'h5a, 1'b1, 1'b0);
        cpu_cycle(16'ha000, 8'h5a, 1'b1, 1'b0);
        cpu_cycle(16'h7000, 8'h07, 1'b1, 1'b0);
    endtask

    task automatic test_sram_paging();
        cfg.mapper = MAPPER_ASCII8;
        cpu_cycle(16'h7000, 8'h46, 1'b1, 1'b0);   // sram bank 6 masked to 2
        cpu_cycle(16'h8010, 8'h00, 1'b0, 1'b0);
        cpu_cycle(16'h9abc, 8'hc3, 1'b1, 1'b0);
        cpu_cycle(16'h7000, 8'h05, 1'b1, 1'b0);   // back to rom
        cpu_cycle(16'h8010, 8'h00, 1'b0, 1'b0);
        cpu_cycle(16'h6000, 8'h41, 1'b1, 1'b0);   // no sram at 0x4000 here
        cpu_cycle(16'h4100, 8'h00, 1'b0, 1'b0);
        cfg.mapper = MAPPER_KOEI;
        cpu_cycle(16'h6000, 8'h41, 1'b1, 1'b0);
        cpu_cycle(16'h4100, 8'h00, 1'b0, 1'b0);
        cpu_cycle(16'h4200, 8'h11, 1'b1, 1'b0);
        cpu_cycle(16'h6000, 8'h03, 1'b1, 1'b0);
        cpu_cycle(16'h4100, 8'h00, 1'b0, 1'b0);
        cfg.mapper = MAPPER_WIZARDY;
        cpu_cycle(16'h7800, 8'h81, 1'b1, 1'b0);
        cpu_cycle(16'ha020, 8'h00, 1'b0, 1'b0);
        cpu_cycle(16'h7800, 8'h42, 1'b1, 1'b0);   // rom bank 0x42 lies beyond the image
        cpu_cycle(16'ha020, 8'h00, 1'b0, 1'b0);
        cpu_cycle(16'h7800, 8'h02, 1'b1, 1'b0);
    endtask

    task automatic test_register_sets();
        bank_t b;
        cfg.mapper = MAPPER_ASCII8;
        for (int r = 0; r < 4; r++) begin
            b = rand_bank(8'h3f);
            cpu_cycle(cpu_addr_t'(32'h6000 + 32'h0800 * r), b, 1'b1, 1'b0);
            cpu_cycle(cpu_addr_t'(32'h6000 + 32'h0800 * r), b ^ 8'h15, 1'b1, 1'b1);
        end
        for (int p = 0; p < 4; p++) begin
            cpu_cycle(cpu_addr_t'(32'h4abc + 32'h2000 * p), 8'h00, 1'b0, 1'b0);
            cpu_cycle(cpu_addr_t'(32'h4abc + 32'h2000 * p), 8'h00, 1'b0, 1'b1);
        end
    endtask

    task automatic test_ascii16();
        bank_t lo;
        bank_t hi;
        cfg.mapper = MAPPER_ASCII16;
        lo = rand_bank(8'h1f);
        hi = rand_bank(8'h1f);
        cpu_cycle(16'h6000, lo, 1'b1, 1'b0);
        cpu_cycle(16'h7000, hi, 1'b1, 1'b0);
        cpu_cycle(16'h67ff, lo ^ 8'h01, 1'b1, 1'b1);
        cpu_cycle(16'h77ff, hi ^ 8'h02, 1'b1, 1'b1);
        cpu_cycle(rand_addr(16'h4000, 16'h3fff), 8'h00, 1'b0, 1'b0);
        cpu_cycle(rand_addr(16'h8000, 16'h3fff), 8'h00, 1'b0, 1'b0);
        cpu_cycle(16'h7fff, 8'h00, 1'b0, 1'b1);
        cpu_cycle(16'hbfff, 8'h00, 1'b0, 1'b1);
        cpu_cycle(16'h6800, lo ^ 8'h10, 1'b1, 1'b0);   // outside both bank windows
        cpu_cycle(16'h7800, hi ^ 8'h08, 1'b1, 1'b0);
        cpu_cycle(16'h4321, 8'h00, 1'b0, 1'b0);
        cpu_cycle(16'h8765, 8'h00, 1'b0, 1'b0);
    endtask

    task automatic test_no_mapper();
        cfg.mapper = MAPPER_NONE;
        cpu_cycle(16'h4000, 8'h00, 1'b0, 1'b0);
        cpu_cycle(16'h8000, 8'h00, 1'b0, 1'b0);
        cfg.mapper = MAPPER_ASCII8;
        cpu_cycle(16'h0000, 8'h00, 1'b0, 1'b0);
        cpu_cycle(16'h3fff, 8'h00, 1'b0, 1'b0);
        cpu_cycle(16'hc000, 8'h00, 1'b0, 1'b0);
        cfg.mapper = MAPPER_ASCII16;
        cpu_cycle(16'h3fff, 8'h00, 1'b0, 1'b0);
        cpu_cycle(16'hffff, 8'h00, 1'b0, 1'b0);
    endtask

    initial begin
        cpu       = '0;
        cfg       = '{mapper: MAPPER_ASCII8, rom_size: ROM_SIZE, sram_size: SRAM_SIZE};
        mapper_id = 1'b0;
        for (int i = 0; i < 2; i++) begin
            ref_sram_en[i]   = '0;
            ref_bank16[i][0] = '0;
            ref_bank16[i][1] = '0;
            for (int j = 0; j < 4; j++) begin
                ref_bank8[i][j]  = '0;
                ref_sbank8[i][j] = '0;
            end
        end
        @(negedge reset);
        @(negedge clk);
        test_reset_state();
        test_ascii8_banks();
        test_sram_paging();
        test_register_sets();
        test_ascii16();
        test_no_mapper();
        $display("errors: %0d mismatches, %0d missing strobes, %0d assertion failures",
                 mismatch_count, missing_count, i_msx_cart.i_chk.fail_count);
        if (mismatch_count + missing_count + i_msx_cart.i_chk.fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== msx_cart.f ====
msx_cart_pkg.sv
cart_ascii8.sv
cart_ascii16.sv
cart_mapper_sel.sv
cart_mem_req.sv
msx_cart.sv
tb_clock.sv
msx_cart_chk.sv
msx_cart_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the msx_cart testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f msx_cart.f --top-module msx_cart_tb -o sim_msx_cart
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_msx_cart)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "^Simulation finished: PASS$"; then
    exit 0
fi
echo "pass message not found"
exit 1
